/* hw/axi_sub_pkg.sv */
// AXI subset definitions
// Fixed widths, payload types and the response and burst codes of the
// reduced AXI channel set used by the ID remapper
`default_nettype none

package axi_sub_pkg;

    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned LEN_WIDTH  = 8;
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [LEN_WIDTH-1:0]  len_t;

    // Response codes on B and R
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // Burst codes as defined by AXI, kept for traffic generation
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

endpackage

`default_nettype wire

/* hw/id_remap_top.sv */
// AXI ID remapper
// Narrows wide manager IDs to slot indices of a per-direction remap table
// and restores them on the way back; W and all payload fields pass through
`timescale 1ns/1ns
`default_nettype none

module id_remap_top #(
    parameter int unsigned ID_IN_WIDTH  = 8,
    parameter int unsigned ID_OUT_WIDTH = 2,
    parameter int unsigned TABLE_SIZE   = remap_pkg::DEFAULT_TABLE_SIZE
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // Manager facing AW
    input  wire logic                    s_aw_valid_i,
    output wire logic                    s_aw_ready_o,
    input  wire logic [ID_IN_WIDTH-1:0]  s_aw_id_i,
    input  wire axi_sub_pkg::addr_t      s_aw_addr_i,
    input  wire axi_sub_pkg::len_t       s_aw_len_i,
    // Manager facing W
    input  wire logic                    s_w_valid_i,
    output wire logic                    s_w_ready_o,
    input  wire axi_sub_pkg::data_t      s_w_data_i,
    input  wire axi_sub_pkg::strb_t      s_w_strb_i,
    input  wire logic                    s_w_last_i,
    // Manager facing B
    output wire logic                    s_b_valid_o,
    input  wire logic                    s_b_ready_i,
    output wire logic [ID_IN_WIDTH-1:0]  s_b_id_o,
    output wire axi_sub_pkg::resp_e      s_b_resp_o,
    // Manager facing AR
    input  wire logic                    s_ar_valid_i,
    output wire logic                    s_ar_ready_o,
    input  wire logic [ID_IN_WIDTH-1:0]  s_ar_id_i,
    input  wire axi_sub_pkg::addr_t      s_ar_addr_i,
    input  wire axi_sub_pkg::len_t       s_ar_len_i,
    // Manager facing R
    output wire logic                    s_r_valid_o,
    input  wire logic                    s_r_ready_i,
    output wire logic [ID_IN_WIDTH-1:0]  s_r_id_o,
    output wire axi_sub_pkg::data_t      s_r_data_o,
    output wire axi_sub_pkg::resp_e      s_r_resp_o,
    output wire logic                    s_r_last_o,

    // Subordinate facing AW
    output wire logic                    m_aw_valid_o,
    input  wire logic                    m_aw_ready_i,
    output wire logic [ID_OUT_WIDTH-1:0] m_aw_id_o,
    output wire axi_sub_pkg::addr_t      m_aw_addr_o,
    output wire axi_sub_pkg::len_t       m_aw_len_o,
    // Subordinate facing W
    output wire logic                    m_w_valid_o,
    input  wire logic                    m_w_ready_i,
    output wire axi_sub_pkg::data_t      m_w_data_o,
    output wire axi_sub_pkg::strb_t      m_w_strb_o,
    output wire logic                    m_w_last_o,
    // Subordinate facing B
    input  wire logic                    m_b_valid_i,
    output wire logic                    m_b_ready_o,
    input  wire logic [ID_OUT_WIDTH-1:0] m_b_id_i,
    input  wire axi_sub_pkg::resp_e      m_b_resp_i,
    // Subordinate facing AR
    output wire logic                    m_ar_valid_o,
    input  wire logic                    m_ar_ready_i,
    output wire logic [ID_OUT_WIDTH-1:0] m_ar_id_o,
    output wire axi_sub_pkg::addr_t      m_ar_addr_o,
    output wire axi_sub_pkg::len_t       m_ar_len_o,
    // Subordinate facing R
    input  wire logic                    m_r_valid_i,
    output wire logic                    m_r_ready_o,
    input  wire logic [ID_OUT_WIDTH-1:0] m_r_id_i,
    input  wire axi_sub_pkg::data_t      m_r_data_i,
    input  wire axi_sub_pkg::resp_e      m_r_resp_i,
    input  wire logic                    m_r_last_i
);

    remap_if #(
        .ID_IN_WIDTH  (ID_IN_WIDTH),
        .ID_OUT_WIDTH (ID_OUT_WIDTH),
        .TABLE_SIZE   (TABLE_SIZE)
    ) wr_if ();

    remap_if #(
        .ID_IN_WIDTH  (ID_IN_WIDTH),
        .ID_OUT_WIDTH (ID_OUT_WIDTH),
        .TABLE_SIZE   (TABLE_SIZE)
    ) rd_if ();

    // Payload fields are untouched
    assign m_aw_addr_o = s_aw_addr_i;
    assign m_aw_len_o  = s_aw_len_i;
    assign m_ar_addr_o = s_ar_addr_i;
    assign m_ar_len_o  = s_ar_len_i;

    // W carries no ID, the whole channel passes straight through
    assign m_w_valid_o = s_w_valid_i;
    assign s_w_ready_o = m_w_ready_i;
    assign m_w_data_o  = s_w_data_i;
    assign m_w_strb_o  = s_w_strb_i;
    assign m_w_last_o  = s_w_last_i;

    assign s_b_resp_o  = m_b_resp_i;
    assign s_r_data_o  = m_r_data_i;
    assign s_r_resp_o  = m_r_resp_i;
    assign s_r_last_o  = m_r_last_i;

    remap_ctrl #(
        .ID_IN_WIDTH  (ID_IN_WIDTH),
        .ID_OUT_WIDTH (ID_OUT_WIDTH),
        .TABLE_SIZE   (TABLE_SIZE)
    ) i_remap_ctrl (
        .s_aw_valid_i (s_aw_valid_i),
        .s_aw_ready_o (s_aw_ready_o),
        .s_aw_id_i    (s_aw_id_i),
        .s_ar_valid_i (s_ar_valid_i),
        .s_ar_ready_o (s_ar_ready_o),
        .s_ar_id_i    (s_ar_id_i),
        .s_b_valid_o  (s_b_valid_o),
        .s_b_ready_i  (s_b_ready_i),
        .s_b_id_o     (s_b_id_o),
        .s_r_valid_o  (s_r_valid_o),
        .s_r_ready_i  (s_r_ready_i),
        .s_r_id_o     (s_r_id_o),
        .m_aw_valid_o (m_aw_valid_o),
        .m_aw_ready_i (m_aw_ready_i),
        .m_aw_id_o    (m_aw_id_o),
        .m_ar_valid_o (m_ar_valid_o),
        .m_ar_ready_i (m_ar_ready_i),
        .m_ar_id_o    (m_ar_id_o),
        .m_b_valid_i  (m_b_valid_i),
        .m_b_ready_o  (m_b_ready_o),
        .m_b_id_i     (m_b_id_i),
        .m_r_valid_i  (m_r_valid_i),
        .m_r_ready_o  (m_r_ready_o),
        .m_r_id_i     (m_r_id_i),
        .m_r_last_i   (m_r_last_i),
        .wr           (wr_if.ctrl),
        .rd           (rd_if.ctrl)
    );

    // AW/B slot table
    remap_table #(
        .ID_IN_WIDTH  (ID_IN_WIDTH),
        .ID_OUT_WIDTH (ID_OUT_WIDTH),
        .TABLE_SIZE   (TABLE_SIZE)
    ) i_wr_table (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .tbl    (wr_if.tbl)
    );

    // AR/R slot table
    remap_table #(
        .ID_IN_WIDTH  (ID_IN_WIDTH),
        .ID_OUT_WIDTH (ID_OUT_WIDTH),
        .TABLE_SIZE   (TABLE_SIZE)
    ) i_rd_table (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .tbl    (rd_if.tbl)
    );

endmodule

`default_nettype wire

/* hw/remap_ctrl.sv */
// Remapper handshake control
// Gates the AW, AR, B and R handshakes with the table status, turns
// completed handshakes into allocate and release strobes and routes the
// remapped IDs onto the channels
`timescale 1ns/1ns
`default_nettype none

module remap_ctrl #(
    parameter int unsigned ID_IN_WIDTH  = 8,
    parameter int unsigned ID_OUT_WIDTH = 2,
    parameter int unsigned TABLE_SIZE   = 4
) (
    // Manager side
    input  wire logic                    s_aw_valid_i,
    output wire logic                    s_aw_ready_o,
    input  wire logic [ID_IN_WIDTH-1:0]  s_aw_id_i,
    input  wire logic                    s_ar_valid_i,
    output wire logic                    s_ar_ready_o,
    input  wire logic [ID_IN_WIDTH-1:0]  s_ar_id_i,
    output wire logic                    s_b_valid_o,
    input  wire logic                    s_b_ready_i,
    output wire logic [ID_IN_WIDTH-1:0]  s_b_id_o,
    output wire logic                    s_r_valid_o,
    input  wire logic                    s_r_ready_i,
    output wire logic [ID_IN_WIDTH-1:0]  s_r_id_o,

    // Subordinate side
    output wire logic                    m_aw_valid_o,
    input  wire logic                    m_aw_ready_i,
    output wire logic [ID_OUT_WIDTH-1:0] m_aw_id_o,
    output wire logic                    m_ar_valid_o,
    input  wire logic                    m_ar_ready_i,
    output wire logic [ID_OUT_WIDTH-1:0] m_ar_id_o,
    input  wire logic                    m_b_valid_i,
    output wire logic                    m_b_ready_o,
    input  wire logic [ID_OUT_WIDTH-1:0] m_b_id_i,
    input  wire logic                    m_r_valid_i,
    output wire logic                    m_r_ready_o,
    input  wire logic [ID_OUT_WIDTH-1:0] m_r_id_i,
    input  wire logic                    m_r_last_i,

    // Write and read tables
    remap_if.ctrl                        wr,
    remap_if.ctrl                        rd
);

    // Write address: hold off the manager while no slot is free
    assign m_aw_valid_o = s_aw_valid_i & ~wr.full;
    assign s_aw_ready_o = m_aw_ready_i & ~wr.full;
    assign m_aw_id_o    = wr.new_id;
    assign wr.orig_id   = s_aw_id_i;
    assign wr.alloc     = s_aw_valid_i & m_aw_ready_i & ~wr.full;

    // Write response: nothing can be outstanding while the table is empty
    assign s_b_valid_o  = m_b_valid_i & ~wr.empty;
    assign m_b_ready_o  = s_b_ready_i & ~wr.empty;
    assign wr.rel_id    = m_b_id_i;
    assign s_b_id_o     = wr.rel_orig_id;
    assign wr.rel       = m_b_valid_i & s_b_ready_i & ~wr.empty;

    // Read address
    assign m_ar_valid_o = s_ar_valid_i & ~rd.full;
    assign s_ar_ready_o = m_ar_ready_i & ~rd.full;
    assign m_ar_id_o    = rd.new_id;
    assign rd.orig_id   = s_ar_id_i;
    assign rd.alloc     = s_ar_valid_i & m_ar_ready_i & ~rd.full;

    // Read data, every beat carries the restored ID
    assign s_r_valid_o  = m_r_valid_i & ~rd.empty;
    assign m_r_ready_o  = s_r_ready_i & ~rd.empty;
    assign rd.rel_id    = m_r_id_i;
    assign s_r_id_o     = rd.rel_orig_id;

    // Slot stays busy until the last beat of the burst
    assign rd.rel       = m_r_valid_i & s_r_ready_i & m_r_last_i & ~rd.empty;

endmodule

`default_nettype wire

/* hw/remap_if.sv */
// Remap table port bundle
// Allocation and release requests from the control logic to one slot table,
// and the table's status and looked-up IDs back
`timescale 1ns/1ns
`default_nettype none

interface remap_if #(
    parameter int unsigned ID_IN_WIDTH  = 8,
    parameter int unsigned ID_OUT_WIDTH = 2,
    parameter int unsigned TABLE_SIZE   = 4
);

    // Requests from the control side
    logic                    alloc;
    logic [ID_IN_WIDTH-1:0]  orig_id;
    logic                    rel;
    logic [ID_OUT_WIDTH-1:0] rel_id;

    // Status and lookups from the table
    logic                    full;
    logic [ID_OUT_WIDTH-1:0] new_id;
    logic [ID_IN_WIDTH-1:0]  rel_orig_id;
    logic                    empty;

    // Every slot index must be expressible as an outgoing ID
    if (TABLE_SIZE < 1 || TABLE_SIZE > (1 << ID_OUT_WIDTH)) begin : g_size_check
        $error("remap_if: TABLE_SIZE %0d does not fit ID_OUT_WIDTH %0d",
               TABLE_SIZE, ID_OUT_WIDTH);
    end

    modport ctrl (
        output alloc, orig_id, rel, rel_id,
        input  full, new_id, rel_orig_id, empty
    );

    modport tbl (
        input  alloc, orig_id, rel, rel_id,
        output full, new_id, rel_orig_id, empty
    );

endinterface

`default_nettype wire

/* hw/remap_pkg.sv */
// Remap table definitions
// Slot state encoding and the default number of table entries
`default_nettype none

package remap_pkg;

    // State of one table entry
    typedef enum logic {
        SLOT_FREE = 1'b0,
        SLOT_BUSY = 1'b1
    } slot_state_e;

    // Outstanding transactions per direction
    localparam int unsigned DEFAULT_TABLE_SIZE = 4;

endpackage

`default_nettype wire

/* hw/remap_table.sv */
// Remap slot table
// Hands out the lowest free slot as the narrow ID, keeps the original wide
// ID per slot and returns it when the slot is looked up and released
`timescale 1ns/1ns
`default_nettype none

module remap_table #(
    parameter int unsigned ID_IN_WIDTH  = 8,
    parameter int unsigned ID_OUT_WIDTH = 2,
    parameter int unsigned TABLE_SIZE   = 4
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    remap_if.tbl      tbl
);

    import remap_pkg::*;

    localparam int unsigned IDX_WIDTH = (TABLE_SIZE > 1) ? $clog2(TABLE_SIZE) : 1;

    slot_state_e            state_q [TABLE_SIZE];
    logic [ID_IN_WIDTH-1:0] orig_q  [TABLE_SIZE];

    logic [IDX_WIDTH-1:0] free_idx;
    logic                 any_free;
    logic                 any_busy;
    logic                 alloc_en;
    logic [IDX_WIDTH-1:0] rel_idx;
    logic                 rel_in_range;
    logic                 rel_en;

    // Scan downwards so the lowest free index wins
    always_comb begin
        free_idx = '0;
        any_free = 1'b0;
        any_busy = 1'b0;
        for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
            if (state_q[i] == SLOT_FREE) begin
                free_idx = IDX_WIDTH'(i);
                any_free = 1'b1;
            end else begin
                any_busy = 1'b1;
            end
        end
    end

    assign tbl.full   = ~any_free;
    assign tbl.empty  = ~any_busy;
    assign tbl.new_id = ID_OUT_WIDTH'(free_idx);

    // A full table ignores a stray allocation request
    assign alloc_en = tbl.alloc & any_free;

    // Returned IDs outside the table never name a slot
    assign rel_idx      = tbl.rel_id[IDX_WIDTH-1:0];
    assign rel_in_range = (int'(tbl.rel_id) < TABLE_SIZE);
    assign rel_en       = tbl.rel & rel_in_range;

    assign tbl.rel_orig_id = rel_in_range ? orig_q[rel_idx] : '0;

    // Allocated and released slots always differ, so both apply on one edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                state_q[i] <= SLOT_FREE;
            end
        end else begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                if (alloc_en && (int'(free_idx) == i)) begin
                    state_q[i] <= SLOT_BUSY;
                end else if (rel_en && (int'(rel_idx) == i)) begin
                    state_q[i] <= SLOT_FREE;
                end
            end
        end
    end

    // Original ID of the slot being allocated
    always_ff @(posedge clk_i) begin
        if (alloc_en) begin
            orig_q[free_idx] <= tbl.orig_id;
        end
    end

endmodule

`default_nettype wire

/* id_remap.f */
hw/axi_sub_pkg.sv
hw/remap_pkg.sv
hw/remap_if.sv
hw/remap_table.sv
hw/remap_ctrl.sv
hw/id_remap_top.sv
tests/id_remap_assertions.sv
tests/tb_id_remap.sv

/* run.sh */
#!/usr/bin/env bash
# Build the ID remapper testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f id_remap.f --top-module tb_id_remap; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_id_remap)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF -- "** PASS **" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tests/id_remap_assertions.sv */
// Handshake checks for the AXI ID remapper
// Table status against the gated handshakes, and address valid stability
`timescale 1ns/1ns
`default_nettype none

module id_remap_assertions (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic wr_full_i,
    input wire logic wr_empty_i,
    input wire logic rd_full_i,
    input wire logic rd_empty_i,
    input wire logic s_aw_ready_i,
    input wire logic s_ar_ready_i,
    input wire logic s_b_valid_i,
    input wire logic s_r_valid_i,
    input wire logic m_aw_valid_i,
    input wire logic m_aw_ready_i,
    input wire logic m_ar_valid_i,
    input wire logic m_ar_ready_i
);

    aw_blocked_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_full_i |-> !s_aw_ready_i)
        else $error("AW ready while the write table is full");

    b_blocked_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_empty_i |-> !s_b_valid_i)
        else $error("B valid while the write table is empty");

    ar_blocked_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_full_i |-> !s_ar_ready_i)
        else $error("AR ready while the read table is full");

    r_blocked_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_empty_i |-> !s_r_valid_i)
        else $error("R valid while the read table is empty");

    // An offered address stays offered until the subordinate takes it
    aw_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (m_aw_valid_i && !m_aw_ready_i) |=> m_aw_valid_i)
        else $error("m_aw_valid dropped under back-pressure");

    ar_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (m_ar_valid_i && !m_ar_ready_i) |=> m_ar_valid_i)
        else $error("m_ar_valid dropped under back-pressure");

endmodule

bind id_remap_top id_remap_assertions i_id_remap_assertions (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_full_i    (wr_if.full),
    .wr_empty_i   (wr_if.empty),
    .rd_full_i    (rd_if.full),
    .rd_empty_i   (rd_if.empty),
    .s_aw_ready_i (s_aw_ready_o),
    .s_ar_ready_i (s_ar_ready_o),
    .s_b_valid_i  (s_b_valid_o),
    .s_r_valid_i  (s_r_valid_o),
    .m_aw_valid_i (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_ar_valid_i (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i)
);

`default_nettype wire

/* tests/tb_id_remap.sv */
// Directed testbench for the AXI ID remapper
// Drives both AXI sides and checks remapped IDs, table back-pressure
// and payload pass-through
`timescale 1ns/1ns
`default_nettype none

module tb_id_remap;

    import axi_sub_pkg::*;

    localparam int unsigned ID_IN_WIDTH  = 8;
    localparam int unsigned ID_OUT_WIDTH = 2;
    localparam int unsigned TABLE_SIZE   = 4;
    localparam int unsigned CLK_PERIOD   = 10;
    localparam int unsigned NUM_TESTS    = 5;
    localparam logic [31:0] LFSR_SEED    = 32'd71450;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    typedef logic [ID_IN_WIDTH-1:0]  id_in_t;
    typedef logic [ID_OUT_WIDTH-1:0] id_out_t;

    logic    clk_i = 1'b0;
    logic    rst_ni;
    logic    s_aw_valid_i, s_aw_ready_o, s_ar_valid_i, s_ar_ready_o;
    logic    s_w_valid_i, s_w_ready_o, s_w_last_i;
    logic    s_b_valid_o, s_b_ready_i, s_r_valid_o, s_r_ready_i, s_r_last_o;
    logic    m_aw_valid_o, m_aw_ready_i, m_ar_valid_o, m_ar_ready_i;
    logic    m_w_valid_o, m_w_ready_i, m_w_last_o;
    logic    m_b_valid_i, m_b_ready_o, m_r_valid_i, m_r_ready_o, m_r_last_i;
    id_in_t  s_aw_id_i, s_ar_id_i, s_b_id_o, s_r_id_o;
    id_out_t m_aw_id_o, m_ar_id_o, m_b_id_i, m_r_id_i;
    addr_t   s_aw_addr_i, s_ar_addr_i, m_aw_addr_o, m_ar_addr_o;
    len_t    s_aw_len_i, s_ar_len_i, m_aw_len_o, m_ar_len_o;
    data_t   s_w_data_i, m_w_data_o, s_r_data_o, m_r_data_i;
    strb_t   s_w_strb_i, m_w_strb_o;
    resp_e   s_b_resp_o, m_b_resp_i, s_r_resp_o, m_r_resp_i;

    logic [31:0] lfsr_q;
    int unsigned check_count;

    id_remap_top #(
        .ID_IN_WIDTH  (ID_IN_WIDTH),
        .ID_OUT_WIDTH (ID_OUT_WIDTH),
        .TABLE_SIZE   (TABLE_SIZE)
    ) i_id_remap_top (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int unsigned n);
        logic [31:0] bits;
        bits = '0;
        for (int unsigned i = 0; i < n; i++) begin
            bits   = {bits[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
        end
        return bits;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp)
            report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic compare_id(input id_in_t got, input id_in_t exp, input string what);
        check_count++;
        if (got !== exp)
            report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic compare_slot(input id_out_t got, input id_out_t exp, input string what);
        check_count++;
        if (got !== exp)
            report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic compare_data(input data_t got, input data_t exp, input string what);
        check_count++;
        if (got !== exp)
            report_mismatch(what, got, exp);
    endtask

    task automatic compare_resp(input resp_e got, input resp_e exp, input string what);
        check_count++;
        if (got !== exp)
            report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic send_aw(input id_in_t id, input id_out_t exp_slot);
        @(posedge clk_i);
        s_aw_valid_i <= 1'b1;
        s_aw_id_i    <= id;
        @(negedge clk_i);
        while (!s_aw_ready_o) @(negedge clk_i);
        compare_flag(m_aw_valid_o, 1'b1, "m_aw_valid");
        compare_slot(m_aw_id_o, exp_slot, "m_aw_id");
        @(posedge clk_i);
        s_aw_valid_i <= 1'b0;
    endtask

    task automatic send_ar(input id_in_t id, input id_out_t exp_slot);
        @(posedge clk_i);
        s_ar_valid_i <= 1'b1;
        s_ar_id_i    <= id;
        @(negedge clk_i);
        while (!s_ar_ready_o) @(negedge clk_i);
        compare_flag(m_ar_valid_o, 1'b1, "m_ar_valid");
        compare_slot(m_ar_id_o, exp_slot, "m_ar_id");
        @(posedge clk_i);
        s_ar_valid_i <= 1'b0;
    endtask

    task automatic send_b(input id_out_t slot, input resp_e resp, input id_in_t exp_id);
        @(posedge clk_i);
        m_b_valid_i <= 1'b1;
        m_b_id_i    <= slot;
        m_b_resp_i  <= resp;
        @(negedge clk_i);
        while (!m_b_ready_o) @(negedge clk_i);
        compare_flag(s_b_valid_o, 1'b1, "s_b_valid");
        compare_id(s_b_id_o, exp_id, "s_b_id");
        compare_resp(s_b_resp_o, resp, "s_b_resp");
        @(posedge clk_i);
        m_b_valid_i <= 1'b0;
    endtask

    task automatic send_r(input id_out_t slot, input data_t data, input resp_e resp,
                          input logic last, input id_in_t exp_id);
        @(posedge clk_i);
        m_r_valid_i <= 1'b1;
        m_r_id_i    <= slot;
        m_r_data_i  <= data;
        m_r_resp_i  <= resp;
        m_r_last_i  <= last;
        @(negedge clk_i);
        while (!m_r_ready_o) @(negedge clk_i);
        compare_flag(s_r_valid_o, 1'b1, "s_r_valid");
        compare_id(s_r_id_o, exp_id, "s_r_id");
        compare_data(s_r_data_o, data, "s_r_data");
        compare_resp(s_r_resp_o, resp, "s_r_resp");
        compare_flag(s_r_last_o, last, "s_r_last");
        @(posedge clk_i);
        m_r_valid_i <= 1'b0;
    endtask

    task automatic test_reset();
        @(negedge clk_i);
        compare_flag(m_aw_valid_o, 1'b0, "m_aw_valid after reset");
        compare_flag(m_ar_valid_o, 1'b0, "m_ar_valid after reset");
        compare_flag(s_b_valid_o, 1'b0, "s_b_valid after reset");
        compare_flag(s_r_valid_o, 1'b0, "s_r_valid after reset");
        compare_flag(m_b_ready_o, 1'b0, "m_b_ready after reset");
        compare_flag(m_r_ready_o, 1'b0, "m_r_ready after reset");
        // Stray B with nothing outstanding
        @(posedge clk_i);
        m_b_valid_i <= 1'b1;
        m_b_id_i    <= 2'd0;
        @(negedge clk_i);
        compare_flag(s_b_valid_o, 1'b0, "s_b_valid on empty table");
        compare_flag(m_b_ready_o, 1'b0, "m_b_ready on empty table");
        @(posedge clk_i);
        m_b_valid_i <= 1'b0;
    endtask

    task automatic test_write_remap();
        id_in_t id_a;
        id_in_t id_b;
        id_a = id_in_t'(random_bits(ID_IN_WIDTH));
        id_b = id_in_t'(random_bits(ID_IN_WIDTH));
        send_aw(id_a, 2'd0);
        // Subordinate stalls the second AW for one cycle
        @(posedge clk_i);
        m_aw_ready_i <= 1'b0;
        s_aw_valid_i <= 1'b1;
        s_aw_id_i    <= id_b;
        @(negedge clk_i);
        compare_flag(m_aw_valid_o, 1'b1, "m_aw_valid while stalled");
        compare_flag(s_aw_ready_o, 1'b0, "s_aw_ready while stalled");
        @(posedge clk_i);
        m_aw_ready_i <= 1'b1;
        @(negedge clk_i);
        compare_flag(s_aw_ready_o, 1'b1, "s_aw_ready after stall");
        compare_slot(m_aw_id_o, 2'd1, "m_aw_id after stall");
        @(posedge clk_i);
        s_aw_valid_i <= 1'b0;
        // Manager stalls the first B, its slot stays busy meanwhile
        @(posedge clk_i);
        s_b_ready_i <= 1'b0;
        m_b_valid_i <= 1'b1;
        m_b_id_i    <= 2'd1;
        m_b_resp_i  <= SLVERR;
        @(negedge clk_i);
        compare_flag(s_b_valid_o, 1'b1, "s_b_valid while stalled");
        compare_flag(m_b_ready_o, 1'b0, "m_b_ready while stalled");
        @(posedge clk_i);
        s_b_ready_i <= 1'b1;
        @(negedge clk_i);
        compare_slot(m_aw_id_o, 2'd2, "free slot while B stalled");
        compare_flag(m_b_ready_o, 1'b1, "m_b_ready after stall");
        compare_id(s_b_id_o, id_b, "s_b_id");
        compare_resp(s_b_resp_o, SLVERR, "s_b_resp");
        @(posedge clk_i);
        m_b_valid_i <= 1'b0;
        send_b(2'd0, OKAY, id_a);
    endtask

    task automatic test_full();
        id_in_t ids [TABLE_SIZE];
        id_in_t id_extra;
        for (int unsigned i = 0; i < TABLE_SIZE; i++) begin
            ids[i] = id_in_t'(random_bits(ID_IN_WIDTH));
            send_aw(ids[i], id_out_t'(i));
        end
        id_extra = id_in_t'(random_bits(ID_IN_WIDTH));
        @(posedge clk_i);
        s_aw_valid_i <= 1'b1;
        s_aw_id_i    <= id_extra;
        @(negedge clk_i);
        compare_flag(s_aw_ready_o, 1'b0, "s_aw_ready with full table");
        compare_flag(m_aw_valid_o, 1'b0, "m_aw_valid with full table");
        // Slot 2 is the only one freed, so the waiting AW must take it
        send_b(2'd2, OKAY, ids[2]);
        @(negedge clk_i);
        compare_flag(s_aw_ready_o, 1'b1, "s_aw_ready after release");
        compare_slot(m_aw_id_o, 2'd2, "m_aw_id after release");
        @(posedge clk_i);
        s_aw_valid_i <= 1'b0;
        send_b(2'd0, EXOKAY, ids[0]);
        send_b(2'd1, DECERR, ids[1]);
        send_b(2'd3, OKAY, ids[3]);
        send_b(2'd2, OKAY, id_extra);
    endtask

    task automatic test_read_burst();
        id_in_t id_burst;
        id_in_t id_second;
        id_in_t id_reuse;
        id_burst  = id_in_t'(random_bits(ID_IN_WIDTH));
        id_second = id_in_t'(random_bits(ID_IN_WIDTH));
        id_reuse  = id_in_t'(random_bits(ID_IN_WIDTH));
        send_ar(id_burst, 2'd0);
        send_r(2'd0, data_t'(random_bits(DATA_WIDTH)), OKAY, 1'b0, id_burst);
        send_r(2'd0, data_t'(random_bits(DATA_WIDTH)), OKAY, 1'b0, id_burst);
        // Open burst still holds slot 0
        send_ar(id_second, 2'd1);
        send_r(2'd0, data_t'(random_bits(DATA_WIDTH)), OKAY, 1'b1, id_burst);
        send_ar(id_reuse, 2'd0);
        send_r(2'd1, data_t'(random_bits(DATA_WIDTH)), SLVERR, 1'b1, id_second);
        send_r(2'd0, data_t'(random_bits(DATA_WIDTH)), OKAY, 1'b1, id_reuse);
    endtask

    task automatic test_pass_through();
        data_t  w_data;
        strb_t  w_strb;
        logic   w_last;
        addr_t  aw_addr;
        addr_t  ar_addr;
        len_t   aw_len;
        len_t   ar_len;
        id_in_t ar_id;
        w_data  = data_t'(random_bits(DATA_WIDTH));
        w_strb  = strb_t'(random_bits(STRB_WIDTH));
        w_last  = 1'(random_bits(1));
        aw_addr = addr_t'(random_bits(ADDR_WIDTH));
        ar_addr = addr_t'(random_bits(ADDR_WIDTH));
        aw_len  = len_t'(random_bits(LEN_WIDTH));
        ar_len  = len_t'(random_bits(LEN_WIDTH));
        ar_id   = id_in_t'(random_bits(ID_IN_WIDTH));
        // W and AR both held off by the subordinate first
        @(posedge clk_i);
        s_w_valid_i  <= 1'b1;
        s_w_data_i   <= w_data;
        s_w_strb_i   <= w_strb;
        s_w_last_i   <= w_last;
        m_w_ready_i  <= 1'b0;
        s_aw_addr_i  <= aw_addr;
        s_aw_len_i   <= aw_len;
        s_ar_valid_i <= 1'b1;
        s_ar_id_i    <= ar_id;
        s_ar_addr_i  <= ar_addr;
        s_ar_len_i   <= ar_len;
        m_ar_ready_i <= 1'b0;
        @(negedge clk_i);
        compare_flag(m_w_valid_o, 1'b1, "m_w_valid");
        compare_flag(s_w_ready_o, 1'b0, "s_w_ready");
        compare_data(m_w_data_o, w_data, "m_w_data");
        compare_data(data_t'(m_w_strb_o), data_t'(w_strb), "m_w_strb");
        compare_flag(m_w_last_o, w_last, "m_w_last");
        compare_data(data_t'(m_aw_addr_o), data_t'(aw_addr), "m_aw_addr");
        compare_data(data_t'(m_aw_len_o), data_t'(aw_len), "m_aw_len");
        compare_data(data_t'(m_ar_addr_o), data_t'(ar_addr), "m_ar_addr");
        compare_data(data_t'(m_ar_len_o), data_t'(ar_len), "m_ar_len");
        compare_flag(m_ar_valid_o, 1'b1, "m_ar_valid while stalled");
        compare_flag(s_ar_ready_o, 1'b0, "s_ar_ready while stalled");
        @(posedge clk_i);
        m_w_ready_i  <= 1'b1;
        m_ar_ready_i <= 1'b1;
        @(negedge clk_i);
        compare_flag(s_w_ready_o, 1'b1, "s_w_ready after stall");
        compare_flag(s_ar_ready_o, 1'b1, "s_ar_ready after stall");
        compare_slot(m_ar_id_o, 2'd0, "m_ar_id after stall");
        @(posedge clk_i);
        s_w_valid_i  <= 1'b0;
        s_ar_valid_i <= 1'b0;
        @(negedge clk_i);
        compare_flag(m_w_valid_o, 1'b0, "m_w_valid after W");
        send_r(2'd0, data_t'(random_bits(DATA_WIDTH)), resp_e'(random_bits(2)), 1'b1,
               ar_id);
    endtask

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        lfsr_q       = LFSR_SEED;
        check_count  = 0;
        rst_ni       <= 1'b0;
        s_aw_valid_i <= 1'b0;
        s_aw_id_i    <= '0;
        s_aw_addr_i  <= '0;
        s_aw_len_i   <= '0;
        s_w_valid_i  <= 1'b0;
        s_w_data_i   <= '0;
        s_w_strb_i   <= '0;
        s_w_last_i   <= 1'b0;
        s_b_ready_i  <= 1'b1;
        s_ar_valid_i <= 1'b0;
        s_ar_id_i    <= '0;
        s_ar_addr_i  <= '0;
        s_ar_len_i   <= '0;
        s_r_ready_i  <= 1'b1;
        m_aw_ready_i <= 1'b1;
        m_w_ready_i  <= 1'b1;
        m_b_valid_i  <= 1'b0;
        m_b_id_i     <= '0;
        m_b_resp_i   <= OKAY;
        m_ar_ready_i <= 1'b1;
        m_r_valid_i  <= 1'b0;
        m_r_id_i     <= '0;
        m_r_data_i   <= '0;
        m_r_resp_i   <= OKAY;
        m_r_last_i   <= 1'b0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_reset();
        test_write_remap();
        test_full();
        test_read_burst();
        test_pass_through();

        @(posedge clk_i);
        if (check_count > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("no checks were run");
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
